//--- Makefile
# Verilator build and run for the NAND command/address issue unit

VERILATOR ?= verilator
TOP       ?= nfcCommandSyncTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/caPinDriver.sv
module caPinDriver
    import nfcPkg::*;
(
    input  logic                     iSystemClock,
    input  logic                     rstN,
    input  logic [numOfWays-1:0]     targetWay,
    input  logic                     caSelect,
    input  logic [caWidth-1:0]       caData,
    caStepIf.pin                     step,
    output logic [2*numOfWays-1:0]   chipEnable,
    output logic [dqWidth-1:0]       dq,
    output logic [laneCount-1:0]     addressLatchEnable,
    output logic [laneCount-1:0]     commandLatchEnable
);

    logic [numOfWays-1:0] wayReg;
    logic                 selReg;     // high for command
    logic [caWidth-1:0]   dataReg;
    logic [caWidth-1:0]   dataShifted;
    logic [7:0]           curByte;

    always_ff @(posedge iSystemClock) begin
        if (step.capture) begin
            wayReg  <= targetWay;
            selReg  <= caSelect;
            dataReg <= caData;
        end
    end

    // msb first, so byte k sits at the top after shifting by k bytes
    assign dataShifted = dataReg << {step.byteIdx, 3'b000};
    assign curByte     = dataShifted[caWidth-1 -: 8];

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            chipEnable         <= '0;
            dq                 <= '0;
            addressLatchEnable <= '0;
            commandLatchEnable <= '0;
        end else begin
            chipEnable <= step.active ? {wayReg, wayReg} : '0;
            dq         <= step.sending ? {laneCount{curByte}} : '0;   // same byte on every lane
            addressLatchEnable <= {laneCount{step.byteFirst && !selReg}};
            commandLatchEnable <= {laneCount{step.byteFirst && selReg}};
        end
    end

    // one kind of latch pulse at a time, one clock wide
    latchEnableExclusive: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        ((|addressLatchEnable) || (|commandLatchEnable)) |->
            !((|addressLatchEnable) && (|commandLatchEnable))
            ##1 (addressLatchEnable == '0 && commandLatchEnable == '0)
    );

    // nothing selected yet in the latch cycle
    chipEnableIdle: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        step.capture |-> chipEnable == '0
    );

endmodule

//--- hdl/caSequencer.sv
module caSequencer
    import nfcPkg::*;
(
    input  logic                    iSystemClock,
    input  logic                    rstN,
    input  logic                    start,
    input  logic [byteIdxWidth-1:0] lastIdx,
    output logic                    ready,
    output logic                    lastStep,
    caStepIf.seq                    step
);

    caState state;
    caState nextState;

    logic [timerWidth-1:0]   byteTimer;
    logic [byteIdxWidth-1:0] byteCount;
    logic [byteIdxWidth-1:0] lastIdxReg;
    logic [byteIdxWidth-1:0] lastIdxClamped;
    logic                    byteDone;
    logic                    finalByte;

    assign byteDone  = (state == caSend) && (byteTimer == timerWidth'(byteHold - 1));
    assign finalByte = byteCount == lastIdxReg;

    // anything past the last byte of the word means the whole word
    assign lastIdxClamped = (lastIdx > byteIdxWidth'(caBytes - 1)) ?
        byteIdxWidth'(caBytes - 1) : lastIdx;

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            state <= caReset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            caReset: nextState = caReady;
            caReady: begin
                // the ready register gates start, so the edge after a word is not taken
                if (start && ready) begin
                    nextState = caLatch;
                end
            end
            caLatch: nextState = caTurn;
            caTurn:  nextState = caSend;
            caSend: begin
                if (byteDone && finalByte) begin
                    nextState = caReady;
                end
            end
            default: nextState = caReset;
        endcase
    end

    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            lastIdxReg <= '0;
        end else if (state == caLatch) begin
            lastIdxReg <= lastIdxClamped;
        end
    end

    // byte timer and byte counter
    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            byteTimer <= '0;
            byteCount <= '0;
        end else if (state != caSend) begin
            byteTimer <= '0;
            byteCount <= '0;
        end else if (byteDone) begin
            byteTimer <= '0;
            byteCount <= byteCount + 1'b1;
        end else begin
            byteTimer <= byteTimer + 1'b1;
        end
    end

    // outputs lag the step signals by one clock, same as the pin registers
    always_ff @(posedge iSystemClock) begin
        if (!rstN) begin
            ready    <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            ready    <= state == caReady;
            lastStep <= byteDone && finalByte;
        end
    end

    assign step.capture   = state == caLatch;
    assign step.active    = (state == caTurn) || (state == caSend);
    assign step.sending   = state == caSend;
    assign step.byteIdx   = byteCount;
    assign step.byteFirst = (state == caSend) && (byteTimer == '0);

    // clamp keeps the counter inside the word
    byteIdxInRange: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        step.sending |-> byteCount <= byteIdxWidth'(caBytes - 1)
    );

    // send already left on the last step, ready follows
    lastStepEndsWord: assert property (
        @(posedge iSystemClock) disable iff (!rstN)
        lastStep |-> !step.sending ##1 ready
    );

endmodule

//--- hdl/caStepIf.sv
interface caStepIf
    import nfcPkg::*;
();

    logic                    capture;     // one cycle, latch state
    logic                    active;      // turnaround through last byte
    logic                    sending;
    logic [byteIdxWidth-1:0] byteIdx;
    logic                    byteFirst;   // first clock of each byte

    modport seq (
        output capture,
        output active,
        output sending,
        output byteIdx,
        output byteFirst
    );

    modport pin (
        input capture,
        input active,
        input sending,
        input byteIdx,
        input byteFirst
    );

endinterface

//--- hdl/nfcCommandSync.sv
module nfcCommandSync
    import nfcPkg::*;
(
    input  logic                     iSystemClock,
    input  logic                     rstN,
    input  logic                     start,
    input  logic [numOfWays-1:0]     targetWay,
    input  logic [byteIdxWidth-1:0]  lastIdx,
    input  logic                     caSelect,
    input  logic [caWidth-1:0]       caData,
    output logic                     ready,
    output logic                     lastStep,
    output logic [2*numOfWays-1:0]   chipEnable,
    output logic [dqWidth-1:0]       dq,
    output logic [laneCount-1:0]     addressLatchEnable,
    output logic [laneCount-1:0]     commandLatchEnable
);

    caStepIf stepBus ();

    caSequencer seq0 (
        .iSystemClock (iSystemClock),
        .rstN         (rstN),
        .start        (start),
        .lastIdx      (lastIdx),
        .ready        (ready),
        .lastStep     (lastStep),
        .step         (stepBus)
    );

    caPinDriver pin0 (
        .iSystemClock       (iSystemClock),
        .rstN               (rstN),
        .targetWay          (targetWay),
        .caSelect           (caSelect),
        .caData             (caData),
        .step               (stepBus),
        .chipEnable         (chipEnable),
        .dq                 (dq),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

endmodule

//--- hdl/nfcPkg.sv
package nfcPkg;

    // flash array geometry
    localparam int numOfWays    = 4;
    localparam int laneCount    = 2;    // byte lanes carrying the same byte

    // command/address word
    localparam int caBytes      = 5;
    localparam int caWidth      = caBytes * 8;
    localparam int byteIdxWidth = 3;

    // each byte is held this many clocks on DQ
    localparam int byteHold     = 3;
    localparam int timerWidth   = $clog2(byteHold);

    localparam int dqWidth      = laneCount * 8;

    // sequencer states
    typedef enum logic [2:0] {
        caReset,
        caReady,
        caLatch,    // capture cycle
        caTurn,     // turnaround, chip enable goes out
        caSend
    } caState;

endpackage

//--- sim.f
hdl/nfcPkg.sv
hdl/caStepIf.sv
hdl/caSequencer.sv
hdl/caPinDriver.sv
hdl/nfcCommandSync.sv
tests/nfcCommandSyncTb.sv

//--- tests/nfcCommandSyncTb.sv
module nfcCommandSyncTb
    import nfcPkg::*;
();

    localparam int numRows = 8;

    typedef struct packed {
        logic [numOfWays-1:0]    way;
        logic [byteIdxWidth-1:0] lastIdx;
        logic                    sel;       // high for command
        logic [caWidth-1:0]      data;
        logic [7:0]              idle;      // ready cycles before start
        logic [7:0]              pokeAt;    // stray start at this offset, 0 for none
        logic                    useLfsr;
    } stimRow;

    logic                    iSystemClock;
    logic                    rstN;
    logic                    start;
    logic [numOfWays-1:0]    targetWay;
    logic [byteIdxWidth-1:0] lastIdx;
    logic                    caSelect;
    logic [caWidth-1:0]      caData;
    logic                    ready;
    logic                    lastStep;
    logic [2*numOfWays-1:0]  chipEnable;
    logic [dqWidth-1:0]      dq;
    logic [laneCount-1:0]    addressLatchEnable;
    logic [laneCount-1:0]    commandLatchEnable;

    stimRow      stimTable [numRows];
    logic [31:0] lfsrState;
    int          cycleCount;
    int          cycleLimit;

    nfcCommandSync dut0 (
        .iSystemClock       (iSystemClock),
        .rstN               (rstN),
        .start              (start),
        .targetWay          (targetWay),
        .lastIdx            (lastIdx),
        .caSelect           (caSelect),
        .caData             (caData),
        .ready              (ready),
        .lastStep           (lastStep),
        .chipEnable         (chipEnable),
        .dq                 (dq),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

    always #2 iSystemClock = ~iSystemClock;

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Checks failed");
            $fatal(1, "run stopped by the watchdog");
        end
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [63:0] takeBits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits[i]   = lfsrState[0];   // one step per bit
        end
        return bits;
    endfunction

    // offset of the last clock of the last byte, counted from the start edge
    function automatic int lastOffset(input stimRow row);
        int lastByte;
        lastByte = (int'(row.lastIdx) > caBytes - 1) ? caBytes - 1 : int'(row.lastIdx);
        return 2 + byteHold * (lastByte + 1);
    endfunction

    task automatic checkValue(
        input string       name,
        input logic [63:0] got,
        input logic [63:0] expected
    );
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic nextCycle();
        @(posedge iSystemClock);
        #1;
    endtask

    task automatic checkResetState(input logic expReady);
        checkValue("ready", 64'(ready), 64'(expReady));
        checkValue("lastStep", 64'(lastStep), 64'(0));
        checkValue("chipEnable", 64'(chipEnable), 64'(0));
        checkValue("dq", 64'(dq), 64'(0));
        checkValue("addressLatchEnable", 64'(addressLatchEnable), 64'(0));
        checkValue("commandLatchEnable", 64'(commandLatchEnable), 64'(0));
    endtask

    // expected pins n clocks after the start edge, n below 0 for an idle cycle
    task automatic checkOutputs(input stimRow row, input int n);
        int                     endOffset;
        int                     k;
        logic [7:0]             expByte;
        logic                   expFirst;
        logic                   expReady;
        logic                   expLast;
        logic [2*numOfWays-1:0] expCe;
        logic [dqWidth-1:0]     expDq;
        logic [laneCount-1:0]   expAle;
        logic [laneCount-1:0]   expCle;

        endOffset = lastOffset(row);
        expReady  = (n < 0) || (n == 0) || (n == endOffset + 1);
        expLast   = n == endOffset;
        expCe     = '0;
        expDq     = '0;
        expAle    = '0;
        expCle    = '0;
        if (n >= 2 && n <= endOffset) begin
            expCe = {row.way, row.way};     // from turnaround on
        end
        if (n >= 3 && n <= endOffset) begin
            k        = (n - 3) / byteHold;
            expByte  = row.data[caWidth - 1 - 8 * k -: 8];    // msb first
            expFirst = ((n - 3) % byteHold) == 0;
            expDq    = {laneCount{expByte}};
            expAle   = {laneCount{expFirst && !row.sel}};
            expCle   = {laneCount{expFirst && row.sel}};
        end
        checkValue("ready", 64'(ready), 64'(expReady));
        checkValue("lastStep", 64'(lastStep), 64'(expLast));
        checkValue("chipEnable", 64'(chipEnable), 64'(expCe));
        checkValue("dq", 64'(dq), 64'(expDq));
        checkValue("addressLatchEnable", 64'(addressLatchEnable), 64'(expAle));
        checkValue("commandLatchEnable", 64'(commandLatchEnable), 64'(expCle));
    endtask

    task automatic runRow(input stimRow row);
        int endOffset;
        endOffset = lastOffset(row);
        for (int i = 0; i < int'(row.idle); i++) begin
            nextCycle();
            checkOutputs(row, -1);
        end
        start     = 1'b1;
        targetWay = row.way;
        lastIdx   = row.lastIdx;
        caSelect  = row.sel;
        caData    = row.data;
        for (int n = 0; n <= endOffset + 1; n++) begin
            nextCycle();
            checkOutputs(row, n);
            start = 1'b0;
            // busy, so this start and its inputs must be dropped
            if (row.pokeAt != 8'd0 && n + 1 == int'(row.pokeAt)) begin
                start     = 1'b1;
                targetWay = numOfWays'(takeBits(numOfWays));
                lastIdx   = byteIdxWidth'(takeBits(byteIdxWidth));
                caSelect  = takeBits(1) == 64'd1;
                caData    = caWidth'(takeBits(caWidth));
            end
        end
    endtask

    task automatic loadTable();
        stimTable[0] = '{4'b0001, 3'd0, 1'b1, 40'h90_1234_5678, 8'd2, 8'd0, 1'b0};
        stimTable[1] = '{4'b0010, 3'd4, 1'b0, 40'h01_2345_6789, 8'd0, 8'd0, 1'b0};
        stimTable[2] = '{4'b0000, 3'd2, 1'b0, 40'h0, 8'd1, 8'd4, 1'b1};
        stimTable[3] = '{4'b0000, 3'd1, 1'b1, 40'h0, 8'd0, 8'd9, 1'b1};   // poke on the ready edge
        stimTable[4] = '{4'b1000, 3'd6, 1'b0, 40'hFE_DCBA_9876, 8'd3, 8'd12, 1'b0};
        stimTable[5] = '{4'b0000, 3'd3, 1'b1, 40'h0, 8'd0, 8'd7, 1'b1};
        stimTable[6] = '{4'b0000, 3'd7, 1'b1, 40'h0, 8'd0, 8'd0, 1'b1};
        stimTable[7] = '{4'b1111, 3'd0, 1'b0, 40'h3C_A500_0000, 8'd5, 8'd6, 1'b0};
        cycleLimit = 20;
        for (int r = 0; r < numRows; r++) begin
            if (stimTable[r].useLfsr) begin
                do begin
                    stimTable[r].way = numOfWays'(takeBits(numOfWays));
                end while (stimTable[r].way == '0);
                stimTable[r].data = caWidth'(takeBits(caWidth));
            end
            cycleLimit += 3 * (int'(stimTable[r].lastIdx) + 1) + 6 + int'(stimTable[r].idle);
        end
    endtask

    initial begin
        iSystemClock = 1'b0;
        rstN         = 1'b0;
        start        = 1'b0;
        targetWay    = '0;
        lastIdx      = '0;
        caSelect     = 1'b0;
        caData       = '0;
        cycleCount   = 0;
        lfsrState    = 32'h2faae9da;
        loadTable();

        repeat (3) begin
            nextCycle();
            checkResetState(1'b0);
        end
        rstN = 1'b1;
        nextCycle();
        checkResetState(1'b0);      // fsm leaves reset, ready one clock later
        nextCycle();
        checkResetState(1'b1);

        for (int r = 0; r < numRows; r++) begin
            runRow(stimTable[r]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule
